// File: hw/mipsPkg.sv
package mipsPkg;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeT;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} jTypeT;

	// One instruction word, read in the format its opcode selects
	typedef union packed {
		rTypeT r;
		iTypeT i;
		jTypeT j;
	} instrT;

	// Opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ       = 6'h02;
	localparam logic [5:0] opJal     = 6'h03;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opBne     = 6'h05;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2b;

	// Function field of SPECIAL
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpT;
	typedef enum logic [1:0] {destRt, destRd, destLink} destSelT;
	typedef enum logic [1:0] {wbAlu, wbLoad, wbLink} wbSrcT;
	typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

	// All zeros is a bubble
	typedef struct packed {
		logic  regWrite;
		logic  memWrite;
		logic  memRead;
		aluOpT aluOp;
		logic  aluSrcImm;
		logic  immZeroExt;
		wbSrcT wbSrc;
		logic  branchEq;
		logic  branchNe;
		logic  jump;
		logic  jumpReg;
		logic  usesRs;
		logic  usesRt;
	} ctrlT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT        ctrl;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  dest;
	} idExT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT        ctrl;
		logic [31:0] result;
		logic [31:0] storeVal;
		logic [4:0]  rt;
		logic [4:0]  dest;
	} exMemT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT        ctrl;
		logic [31:0] result;
		logic [4:0]  dest;
	} memWbT;

endpackage

// File: hw/fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit #(
	parameter logic [31:0] resetPc = 32'h0000_3000
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           stall,
	input  logic           branchTaken,
	input  logic           jump,
	input  logic           jumpReg,
	input  logic [31:0]    decodePc,
	input  mipsPkg::instrT decodeInstr,
	input  logic [31:0]    regTarget,
	output logic [31:0]    pc
);
	logic [31:0] slotPc;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [31:0] nextPc;

	assign slotPc = decodePc + 32'd4;	// Delay slot address
	assign branchTarget = slotPc + {{14{decodeInstr.i.imm[15]}}, decodeInstr.i.imm, 2'b00};
	assign jumpTarget = {slotPc[31:28], decodeInstr.j.target, 2'b00};

	always_comb begin
		if (jumpReg)
			nextPc = regTarget;
		else if (jump)
			nextPc = jumpTarget;
		else if (branchTaken)
			nextPc = branchTarget;
		else
			nextPc = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= resetPc;
		else if (!stall)
			pc <= nextPc;
	end

endmodule

// File: hw/decodeCtrl.sv
`timescale 1ns/100ps

module decodeCtrl (
	input  mipsPkg::instrT instr,
	output mipsPkg::ctrlT  ctrl,
	output logic [4:0]     dest
);
	mipsPkg::ctrlT    raw;
	mipsPkg::destSelT destSel;

	always_comb begin
		raw = '0;
		destSel = mipsPkg::destRt;
		case (instr.r.opcode)
			mipsPkg::opSpecial: begin
				raw.regWrite = 1'b1;
				raw.usesRs = 1'b1;
				raw.usesRt = 1'b1;
				destSel = mipsPkg::destRd;
				case (instr.r.funct)
					mipsPkg::fnAddu: raw.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSubu: raw.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd:  raw.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:   raw.aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt:  raw.aluOp = mipsPkg::aluSlt;
					mipsPkg::fnJr: begin
						raw.regWrite = 1'b0;
						raw.usesRt = 1'b0;
						raw.jumpReg = 1'b1;
					end
					default: raw = '0;	// Unsupported, runs as nop
				endcase
			end
			mipsPkg::opAddiu: begin
				raw.regWrite = 1'b1;
				raw.aluSrcImm = 1'b1;
				raw.usesRs = 1'b1;
			end
			mipsPkg::opOri: begin
				raw.regWrite = 1'b1;
				raw.aluOp = mipsPkg::aluOr;
				raw.aluSrcImm = 1'b1;
				raw.immZeroExt = 1'b1;
				raw.usesRs = 1'b1;
			end
			mipsPkg::opLui: begin
				raw.regWrite = 1'b1;
				raw.aluOp = mipsPkg::aluLui;
				raw.aluSrcImm = 1'b1;
			end
			mipsPkg::opLw: begin
				raw.regWrite = 1'b1;
				raw.memRead = 1'b1;
				raw.aluSrcImm = 1'b1;
				raw.wbSrc = mipsPkg::wbLoad;
				raw.usesRs = 1'b1;
			end
			mipsPkg::opSw: begin
				raw.memWrite = 1'b1;
				raw.aluSrcImm = 1'b1;
				raw.usesRs = 1'b1;
				raw.usesRt = 1'b1;	// Store data
			end
			mipsPkg::opBeq, mipsPkg::opBne: begin
				raw.branchEq = (instr.i.opcode == mipsPkg::opBeq);
				raw.branchNe = (instr.i.opcode == mipsPkg::opBne);
				raw.usesRs = 1'b1;
				raw.usesRt = 1'b1;
			end
			mipsPkg::opJ: raw.jump = 1'b1;
			mipsPkg::opJal: begin
				raw.jump = 1'b1;
				raw.regWrite = 1'b1;
				raw.wbSrc = mipsPkg::wbLink;
				destSel = mipsPkg::destLink;
			end
			default: raw = '0;
		endcase
	end

	always_comb begin
		case (destSel)
			mipsPkg::destRd:   dest = instr.r.rd;
			mipsPkg::destLink: dest = 5'd31;
			default:           dest = instr.r.rt;
		endcase
		ctrl = raw;
		// Writes to r0 vanish here, later stages never check for it
		ctrl.regWrite = raw.regWrite && (dest != 5'd0);
	end

endmodule

// File: hw/regFile.sv
`timescale 1ns/100ps

module regFile (
	input  logic        clk,
	input  logic        reset,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [4:0]  raddrA,
	input  logic [4:0]  raddrB,
	input  logic [31:0] wdata,
	output logic [31:0] rdataA,
	output logic [31:0] rdataB
);
	logic [31:0] regs [1:31];

	// Same-cycle write shows through to the read ports
	function automatic logic [31:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0)
			return 32'd0;
		if (we && addr == waddr)
			return wdata;
		return regs[addr];
	endfunction

	always_comb begin
		rdataA = readPort(raddrA);
		rdataB = readPort(raddrB);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

// File: hw/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
	input  mipsPkg::ctrlT   decodeCtrl,
	input  logic [4:0]      decodeRs,
	input  logic [4:0]      decodeRt,
	input  mipsPkg::idExT   idEx,
	input  mipsPkg::exMemT  exMem,
	input  mipsPkg::memWbT  memWb,
	output logic            stall,
	output mipsPkg::fwdSelT fwdDecRs,
	output mipsPkg::fwdSelT fwdDecRt,
	output mipsPkg::fwdSelT fwdExRs,
	output mipsPkg::fwdSelT fwdExRt
);
	logic earlyUse;	// Branch or jr compares in decode
	logic exHitRs;
	logic exHitRt;
	logic memHitRs;
	logic memHitRt;
	logic loadUse;
	logic branchWait;
	logic branchLoad;

	// Memory stage first, then write-back
	function automatic mipsPkg::fwdSelT execSel(input logic [4:0] src, input logic uses,
			input mipsPkg::exMemT m, input mipsPkg::memWbT w);
		if (uses && m.ctrl.regWrite && !m.ctrl.memRead && m.dest == src)
			return mipsPkg::fwdMem;
		if (uses && w.ctrl.regWrite && w.dest == src)
			return mipsPkg::fwdWb;
		return mipsPkg::fwdNone;
	endfunction

	assign earlyUse = decodeCtrl.branchEq || decodeCtrl.branchNe || decodeCtrl.jumpReg;

	assign exHitRs = decodeCtrl.usesRs && idEx.ctrl.regWrite && idEx.dest == decodeRs;
	assign exHitRt = decodeCtrl.usesRt && idEx.ctrl.regWrite && idEx.dest == decodeRt;
	assign memHitRs = decodeCtrl.usesRs && exMem.ctrl.regWrite && exMem.dest == decodeRs;
	assign memHitRt = decodeCtrl.usesRt && exMem.ctrl.regWrite && exMem.dest == decodeRt;

	assign loadUse = idEx.ctrl.memRead && (exHitRs || exHitRt);
	assign branchWait = earlyUse && (exHitRs || exHitRt);
	assign branchLoad = earlyUse && exMem.ctrl.memRead && (memHitRs || memHitRt);	// Second stall
	assign stall = loadUse || branchWait || branchLoad;

	// Write-back into decode goes through the register file bypass
	assign fwdDecRs = (memHitRs && !exMem.ctrl.memRead) ? mipsPkg::fwdMem : mipsPkg::fwdNone;
	assign fwdDecRt = (memHitRt && !exMem.ctrl.memRead) ? mipsPkg::fwdMem : mipsPkg::fwdNone;

	assign fwdExRs = execSel(idEx.rs, idEx.ctrl.usesRs, exMem, memWb);
	assign fwdExRt = execSel(idEx.rt, idEx.ctrl.usesRt, exMem, memWb);

endmodule

// File: hw/aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
	input  mipsPkg::aluOpT op,
	input  logic [31:0]    a,
	input  logic [31:0]    b,
	output logic [31:0]    result
);

	always_comb begin
		case (op)
			mipsPkg::aluAdd: result = a + b;	// Wraps, no overflow trap
			mipsPkg::aluSub: result = a - b;
			mipsPkg::aluAnd: result = a & b;
			mipsPkg::aluOr:  result = a | b;
			mipsPkg::aluSlt: result = {31'd0, $signed(a) < $signed(b)};
			mipsPkg::aluLui: result = {b[15:0], 16'd0};
			default:         result = '0;
		endcase
	end

endmodule

// File: hw/mips.sv
`timescale 1ns/100ps

module mips #(
	parameter logic [31:0] resetPc = 32'h0000_3000
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] instData,
	input  logic [31:0] dataRdata,
	output logic [31:0] instAddr,
	output logic [31:0] dataAddr,
	output logic [31:0] dataWdata,
	output logic        dataWe,
	output logic        wbWe,
	output logic [4:0]  wbAddr,
	output logic [31:0] wbData,
	output logic [31:0] wbPc
);
	logic [31:0]     ifIdPc;
	mipsPkg::instrT  ifIdInstr;
	mipsPkg::ctrlT   decCtrl;
	logic [4:0]      decDest;
	logic [31:0]     rfRs;
	logic [31:0]     rfRt;
	logic [31:0]     decRsVal;
	logic [31:0]     decRtVal;
	logic [31:0]     decImm;
	logic            branchTaken;
	logic            stall;
	mipsPkg::fwdSelT fwdDecRs;
	mipsPkg::fwdSelT fwdDecRt;
	mipsPkg::fwdSelT fwdExRs;
	mipsPkg::fwdSelT fwdExRt;
	mipsPkg::idExT   idEx;
	mipsPkg::idExT   idExNext;
	mipsPkg::exMemT  exMem;
	mipsPkg::exMemT  exMemNext;
	mipsPkg::memWbT  memWb;
	mipsPkg::memWbT  memWbNext;
	logic [31:0]     exA;
	logic [31:0]     exRtVal;
	logic [31:0]     exB;
	logic [31:0]     aluOut;

	function automatic logic [31:0] pickOperand(input mipsPkg::fwdSelT sel,
			input logic [31:0] regVal, input logic [31:0] memVal, input logic [31:0] wbVal);
		case (sel)
			mipsPkg::fwdMem: return memVal;
			mipsPkg::fwdWb:  return wbVal;
			default:         return regVal;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Fetch

	fetchUnit #(.resetPc(resetPc)) fetch0 (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.branchTaken(branchTaken),
		.jump(decCtrl.jump),
		.jumpReg(decCtrl.jumpReg),
		.decodePc(ifIdPc),
		.decodeInstr(ifIdInstr),
		.regTarget(decRsVal),	// jr target after forwarding
		.pc(instAddr)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			ifIdPc <= '0;
			ifIdInstr <= '0;	// All zero word decodes as nop
		end else if (!stall) begin
			ifIdPc <= instAddr;
			ifIdInstr <= instData;
		end
	end

	////////////////////////////////////////////////////////////
	// Decode

	decodeCtrl decode0 (
		.instr(ifIdInstr),
		.ctrl(decCtrl),
		.dest(decDest)
	);

	regFile regs0 (
		.clk(clk),
		.reset(reset),
		.we(wbWe),
		.waddr(wbAddr),
		.raddrA(ifIdInstr.r.rs),
		.raddrB(ifIdInstr.r.rt),
		.wdata(wbData),
		.rdataA(rfRs),
		.rdataB(rfRt)
	);

	hazardUnit hazard0 (
		.decodeCtrl(decCtrl),
		.decodeRs(ifIdInstr.r.rs),
		.decodeRt(ifIdInstr.r.rt),
		.idEx(idEx),
		.exMem(exMem),
		.memWb(memWb),
		.stall(stall),
		.fwdDecRs(fwdDecRs),
		.fwdDecRt(fwdDecRt),
		.fwdExRs(fwdExRs),
		.fwdExRt(fwdExRt)
	);

	assign decRsVal = pickOperand(fwdDecRs, rfRs, exMem.result, memWb.result);
	assign decRtVal = pickOperand(fwdDecRt, rfRt, exMem.result, memWb.result);
	assign decImm = decCtrl.immZeroExt ? {16'd0, ifIdInstr.i.imm}
		: {{16{ifIdInstr.i.imm[15]}}, ifIdInstr.i.imm};

	// Branch compare in decode, delay slot already fetched
	assign branchTaken = (decCtrl.branchEq && decRsVal == decRtVal)
		|| (decCtrl.branchNe && decRsVal != decRtVal);

	assign idExNext = '{pc: ifIdPc, ctrl: decCtrl, rsVal: decRsVal, rtVal: decRtVal,
		imm: decImm, rs: ifIdInstr.r.rs, rt: ifIdInstr.r.rt, dest: decDest};

	always_ff @(posedge clk) begin
		idEx <= idExNext;
		if (reset || stall)
			idEx.ctrl <= '0;	// Bubble
	end

	////////////////////////////////////////////////////////////
	// Execute

	assign exA = pickOperand(fwdExRs, idEx.rsVal, exMem.result, memWb.result);
	assign exRtVal = pickOperand(fwdExRt, idEx.rtVal, exMem.result, memWb.result);
	assign exB = idEx.ctrl.aluSrcImm ? idEx.imm : exRtVal;

	aluUnit alu0 (
		.op(idEx.ctrl.aluOp),
		.a(exA),
		.b(exB),
		.result(aluOut)
	);

	// Link value is made here so it forwards like any ALU result
	assign exMemNext = '{pc: idEx.pc, ctrl: idEx.ctrl,
		result: (idEx.ctrl.wbSrc == mipsPkg::wbLink) ? idEx.pc + 32'd8 : aluOut,
		storeVal: exRtVal, rt: idEx.rt, dest: idEx.dest};

	always_ff @(posedge clk) begin
		exMem <= exMemNext;
		if (reset)
			exMem.ctrl <= '0;
	end

	////////////////////////////////////////////////////////////
	// Memory

	assign dataAddr = exMem.result;
	assign dataWdata = exMem.storeVal;
	assign dataWe = exMem.ctrl.memWrite;

	assign memWbNext = '{pc: exMem.pc, ctrl: exMem.ctrl,
		result: (exMem.ctrl.wbSrc == mipsPkg::wbLoad) ? dataRdata : exMem.result,
		dest: exMem.dest};

	always_ff @(posedge clk) begin
		memWb <= memWbNext;
		if (reset)
			memWb.ctrl <= '0;
	end

	////////////////////////////////////////////////////////////
	// Write-back and trace

	assign wbWe = memWb.ctrl.regWrite;
	assign wbAddr = memWb.dest;
	assign wbData = memWb.result;
	assign wbPc = memWb.pc;

endmodule

// File: tb/mipsTb.sv
`timescale 1ns/100ps

module mipsTb;

	localparam int clkPeriod = 8;
	localparam logic [31:0] resetPc = 32'h0000_3000;
	localparam int bodyLen = 48;
	localparam int subLen = 3;	// ALU words before the jr
	localparam int subStart = bodyLen + 2;
	localparam logic [31:0] loopPc = resetPc + 4 * bodyLen;
	localparam int progWords = bodyLen + 2 + subLen + 2;
	localparam int numTests = 6;
	localparam int watchCycles = numTests * (3 * progWords + 100);

	localparam int modeAlu = 0;
	localparam int modeMem = 1;
	localparam int modeBranch = 2;
	localparam int modeMixed = 3;
	localparam int modeZero = 4;

	typedef struct packed {
		logic [4:0]  addr;
		logic [31:0] data;
		logic [31:0] pc;
	} regWriteT;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} memWriteT;

	logic        clk;
	logic        reset;
	logic [31:0] instData;
	logic [31:0] dataRdata;
	logic [31:0] instAddr;
	logic [31:0] dataAddr;
	logic [31:0] dataWdata;
	logic        dataWe;
	logic        wbWe;
	logic [4:0]  wbAddr;
	logic [31:0] wbData;
	logic [31:0] wbPc;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:63];
	logic [31:0] modelReg [0:31];
	logic [31:0] modelMem [0:63];
	regWriteT    expRegQ [$];
	memWriteT    expMemQ [$];
	logic [31:0] rngState = 32'h8483402f;
	string       testName = "none";
	int          errorCount = 0;
	int          failedTests = 0;
	int          regSeen = 0;
	int          memSeen = 0;
	int          regTotal = 0;
	int          memTotal = 0;

	mips dut0 (
		.clk(clk),
		.reset(reset),
		.instData(instData),
		.dataRdata(dataRdata),
		.instAddr(instAddr),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.dataWe(dataWe),
		.wbWe(wbWe),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.wbPc(wbPc)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Both memories answer in the same cycle
	assign instData = imem[instAddr[9:2]];
	assign dataRdata = dmem[dataAddr[7:2]];

	always @(posedge clk) begin
		if (!reset && dataWe === 1'b1)
			dmem[dataAddr[7:2]] <= dataWdata;
	end

	////////////////////////////////////////////////////////////
	// Program generation

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Mostly r0..r7 so neighbours depend on each other, never r31
	function automatic logic [4:0] pickReg(input logic zeroBias);
		logic [31:0] r;
		r = nextRand();
		if (zeroBias && r[1])
			return 5'd0;
		if (r[0])
			return {2'b00, r[4:2]};
		return r[12:8] % 5'd31;
	endfunction

	function automatic logic [31:0] aluInstr(input logic zeroBias);
		logic [31:0] r;
		logic [4:0]  d;
		logic [4:0]  s;
		logic [4:0]  t;
		r = nextRand();
		d = pickReg(zeroBias);
		s = pickReg(1'b0);
		t = pickReg(1'b0);
		case (r[2:0])
			3'd0: return {mipsPkg::opSpecial, s, t, d, 5'd0, mipsPkg::fnAddu};
			3'd1: return {mipsPkg::opSpecial, s, t, d, 5'd0, mipsPkg::fnSubu};
			3'd2: return {mipsPkg::opSpecial, s, t, d, 5'd0, mipsPkg::fnAnd};
			3'd3: return {mipsPkg::opSpecial, s, t, d, 5'd0, mipsPkg::fnOr};
			3'd4: return {mipsPkg::opSpecial, s, t, d, 5'd0, mipsPkg::fnSlt};
			3'd5: return {mipsPkg::opAddiu, s, d, r[31:16]};
			3'd6: return {mipsPkg::opOri, s, d, r[31:16]};
			default: return {mipsPkg::opLui, 5'd0, d, r[31:16]};
		endcase
	endfunction

	function automatic logic [31:0] memInstr(input logic zeroBias);
		logic [31:0] r;
		logic [15:0] off;
		r = nextRand();
		off = {8'd0, r[7:2], 2'b00};	// Word inside the 64-word area
		if (r[0])
			return {mipsPkg::opLw, 5'd0, pickReg(zeroBias), off};
		return {mipsPkg::opSw, 5'd0, pickReg(1'b0), off};
	endfunction

	function automatic logic [31:0] plainInstr(input int mode);
		if ((mode == modeMem || mode == modeMixed) && nextRand() % 5 < 2)
			return memInstr(1'b0);
		return aluInstr(mode == modeZero);
	endfunction

	function automatic logic [25:0] jumpField(input int idx);
		logic [31:0] addr;
		addr = resetPc + 32'(idx) * 4;
		return addr[27:2];
	endfunction

	function automatic logic [31:0] fillWord(input int idx, input int test);
		return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ 32'(test);
	endfunction

	// Body, end loop, then the subroutine that jal calls
	task automatic genProgram(input int mode);
		int          i;
		int          t;
		int          jals;
		logic [31:0] r;
		logic [4:0]  s;
		logic [4:0]  rtReg;
		logic [15:0] off;
		for (int n = 0; n < 256; n++)
			imem[n] = 32'h0;
		i = 0;
		jals = 0;
		while (i < bodyLen) begin
			r = nextRand();
			if ((mode == modeBranch || mode == modeMixed) && i < bodyLen - 1 && r[2:0] < 3'd2) begin
				t = i + 2 + r[10:8] % 5;	// Forward only
				if (t > bodyLen)
					t = bodyLen;
				s = pickReg(1'b0);
				rtReg = r[5] ? s : (r[6] ? 5'd0 : pickReg(1'b0));
				off = 16'(t - (i + 1));
				case (r[4:3])
					2'd0: imem[i] = {mipsPkg::opBeq, s, rtReg, off};
					2'd1: imem[i] = {mipsPkg::opBne, s, rtReg, off};
					2'd2: imem[i] = {mipsPkg::opJ, jumpField(t)};
					default: begin
						if (jals < 4) begin
							imem[i] = {mipsPkg::opJal, jumpField(subStart)};
							jals++;
						end else begin
							imem[i] = {mipsPkg::opJ, jumpField(t)};
						end
					end
				endcase
				imem[i + 1] = plainInstr(mode);	// Delay slot
				i += 2;
			end else begin
				imem[i] = plainInstr(mode);
				i++;
			end
		end
		imem[bodyLen] = 32'h1000_ffff;	// beq r0, r0 back onto itself
		for (int n = 0; n < subLen; n++)
			imem[subStart + n] = aluInstr(1'b0);
		imem[subStart + subLen] = {mipsPkg::opSpecial, 5'd31, 15'd0, mipsPkg::fnJr};
		imem[subStart + subLen + 1] = aluInstr(1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// Instruction-level model

	task automatic modelWrite(input logic [4:0] idx, input logic [31:0] val,
			input logic [31:0] pc);
		regWriteT w;
		if (idx != 5'd0) begin
			modelReg[idx] = val;
			w.addr = idx;
			w.data = val;
			w.pc = pc;
			expRegQ.push_back(w);
		end
	endtask

	task automatic runModel();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nxt;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] addr;
		memWriteT    mw;
		int          steps;
		for (int n = 0; n < 32; n++)
			modelReg[n] = 32'd0;
		for (int n = 0; n < 64; n++)
			modelMem[n] = dmem[n];
		expRegQ.delete();
		expMemQ.delete();
		pc = resetPc;
		npc = resetPc + 32'd4;
		steps = 0;
		while (pc != loopPc && steps < 4000) begin
			ins = imem[pc[9:2]];
			a = modelReg[ins[25:21]];
			b = modelReg[ins[20:16]];
			sx = {{16{ins[15]}}, ins[15:0]};
			addr = a + sx;
			nxt = npc + 32'd4;	// npc is the delay slot
			case (ins[31:26])
				mipsPkg::opSpecial: begin
					case (ins[5:0])
						mipsPkg::fnAddu: modelWrite(ins[15:11], a + b, pc);
						mipsPkg::fnSubu: modelWrite(ins[15:11], a - b, pc);
						mipsPkg::fnAnd:  modelWrite(ins[15:11], a & b, pc);
						mipsPkg::fnOr:   modelWrite(ins[15:11], a | b, pc);
						mipsPkg::fnSlt:  modelWrite(ins[15:11], {31'd0, $signed(a) < $signed(b)}, pc);
						mipsPkg::fnJr:   nxt = a;
						default: ;
					endcase
				end
				mipsPkg::opAddiu: modelWrite(ins[20:16], a + sx, pc);
				mipsPkg::opOri:   modelWrite(ins[20:16], a | {16'd0, ins[15:0]}, pc);
				mipsPkg::opLui:   modelWrite(ins[20:16], {ins[15:0], 16'd0}, pc);
				mipsPkg::opLw:    modelWrite(ins[20:16], modelMem[addr[7:2]], pc);
				mipsPkg::opSw: begin
					modelMem[addr[7:2]] = b;
					mw.addr = addr;
					mw.data = b;
					expMemQ.push_back(mw);
				end
				mipsPkg::opBeq: if (a == b) nxt = npc + {sx[29:0], 2'b00};
				mipsPkg::opBne: if (a != b) nxt = npc + {sx[29:0], 2'b00};
				mipsPkg::opJ:   nxt = {npc[31:28], ins[25:0], 2'b00};
				mipsPkg::opJal: begin
					nxt = {npc[31:28], ins[25:0], 2'b00};
					modelWrite(5'd31, pc + 32'd8, pc);
				end
				default: ;
			endcase
			pc = npc;
			npc = nxt;
			steps++;
		end
		if (pc != loopPc) begin
			$display("test %s: model never reached the end loop", testName);
			errorCount++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Trace checkers

	always @(negedge clk) begin
		regWriteT got;
		regWriteT want;
		memWriteT gotM;
		memWriteT wantM;
		if (!reset) begin
			if (wbWe === 1'b1) begin
				got.addr = wbAddr;
				got.data = wbData;
				got.pc = wbPc;
				if (wbAddr == 5'd0) begin
					$display("test %s: write strobe raised for r0 at pc %h", testName, wbPc);
					errorCount++;
				end
				if (expRegQ.size() == 0) begin
					$display("test %s: unexpected register write r%0d=%h at pc %h", testName,
						wbAddr, wbData, wbPc);
					errorCount++;
				end else begin
					want = expRegQ.pop_front();
					if (got !== want) begin
						$display("error: test %s write %0d: expected r%0d=%h pc %h, actual r%0d=%h pc %h",
							testName, regSeen, want.addr, want.data, want.pc, got.addr, got.data, got.pc);
						errorCount++;
					end
				end
				regSeen++;
			end
			if (dataWe === 1'b1) begin
				gotM.addr = dataAddr;
				gotM.data = dataWdata;
				if (expMemQ.size() == 0) begin
					$display("test %s: unexpected store of %h to %h", testName, dataWdata, dataAddr);
					errorCount++;
				end else begin
					wantM = expMemQ.pop_front();
					if (gotM !== wantM) begin
						$display("error: test %s store %0d: expected [%h]=%h, actual [%h]=%h",
							testName, memSeen, wantM.addr, wantM.data, gotM.addr, gotM.data);
						errorCount++;
					end
				end
				memSeen++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	function automatic string nameOf(input int t);
		case (t)
			0: return "alu";
			1: return "mem";
			2: return "branch";
			3: return "mixed";
			4: return "mixed2";
			default: return "zero";
		endcase
	endfunction

	function automatic int modeOf(input int t);
		case (t)
			0: return modeAlu;
			1: return modeMem;
			2: return modeBranch;
			3, 4: return modeMixed;
			default: return modeZero;
		endcase
	endfunction

	task automatic runTest(input int t);
		int errorsBefore;
		errorsBefore = errorCount;
		testName = nameOf(t);
		@(posedge clk);
		#1 reset = 1'b1;
		genProgram(modeOf(t));
		for (int n = 0; n < 64; n++)
			dmem[n] = fillWord(n, t);
		runModel();
		regTotal = expRegQ.size();
		memTotal = expMemQ.size();
		regSeen = 0;
		memSeen = 0;
		@(posedge clk);
		@(negedge clk);
		if (wbWe !== 1'b0 || dataWe !== 1'b0) begin
			$display("test %s: write strobe not low during reset", testName);
			errorCount++;
		end
		@(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		if (instAddr !== resetPc) begin
			$display("error: test %s first fetch: expected %h, actual %h", testName, resetPc, instAddr);
			errorCount++;
		end
		if (wbWe !== 1'b0 || dataWe !== 1'b0) begin
			$display("test %s: write strobe high in the first cycle after reset", testName);
			errorCount++;
		end
		while (regSeen < regTotal || memSeen < memTotal || instAddr != loopPc) begin
			@(negedge clk);
			#1;
		end
		repeat (8) @(negedge clk);	// Stray writes would show up here
		#1;
		if (regSeen != regTotal) begin
			$display("error: test %s register writes: expected %0d, actual %0d", testName,
				regTotal, regSeen);
			errorCount++;
		end
		if (memSeen != memTotal) begin
			$display("error: test %s stores: expected %0d, actual %0d", testName, memTotal, memSeen);
			errorCount++;
		end
		if (errorCount == errorsBefore) begin
			$display("test %-6s ok, %0d register writes, %0d stores", testName, regTotal, memTotal);
		end else begin
			failedTests++;
			$display("test %-6s failed, %0d errors", testName, errorCount - errorsBefore);
		end
	endtask

	initial begin
		reset = 1'b1;
		for (int t = 0; t < numTests; t++)
			runTest(t);
		$display("tests %0d, failed %0d, errors %0d", numTests, failedTests, errorCount);
		if (failedTests == 0 && errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Three cycles per word covers two stalls per instruction
	initial begin
		#(clkPeriod * watchCycles);
		$display("timeout: test %s stuck after %0d cycles, %0d of %0d register writes seen",
			testName, watchCycles, regSeen, regTotal);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: mipsCore.f
hw/mipsPkg.sv
hw/fetchUnit.sv
hw/decodeCtrl.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/aluUnit.sv
hw/mips.sv
tb/mipsTb.sv
